/* build.f */
hw/aes_pkg.sv
hw/aes_ctrl_pkg.sv
hw/sbox_rom.sv
hw/round_key_rom.sv
hw/sub_shift_unit.sv
hw/mix_add_unit.sv
hw/aes256_enc.sv
tb/tb_aes256_enc.sv

/* hw/aes256_enc.sv */
// AES-256 encryption top with round sequencer
// Hosts the SubBytes/ShiftRows unit and the MixColumns/AddRoundKey unit

module aes256_enc (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      start,
    input  aes_pkg::block_t           plaintext,
    output aes_pkg::block_t           ciphertext,
    output aes_ctrl_pkg::enc_status_t status
);

    aes_ctrl_pkg::enc_state_e state;
    aes_pkg::round_t          round;
    aes_pkg::round_t          key_round;
    logic                     done_q;
    logic                     accept;
    logic                     last;

    // Handshake between the two round stages
    logic            ss_go;
    logic            ss_done;
    logic            ma_go;
    logic            ma_done;
    aes_pkg::block_t ss_out;
    aes_pkg::block_t ma_in;
    aes_pkg::block_t ma_out;

    // Start only counts when idle
    assign accept = (state == aes_ctrl_pkg::IDLE) && start;
    assign last   = (round == aes_pkg::NUM_ROUNDS);

    // Round 0 adds the key to the plaintext in the start cycle
    assign ma_go = accept || ss_done;
    assign ma_in = (state == aes_ctrl_pkg::IDLE) ? plaintext : ss_out;
    // Each finished add starts the next SubBytes unless this was round 14
    assign ss_go = ma_done && !last;

    // Park the key ROM on round 0 while the last round finishes
    // so key 0 is ready for a back-to-back start
    assign key_round = (state == aes_ctrl_pkg::MIXADD && last) ? '0 : round;

    sub_shift_unit sub_shift_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .go        (ss_go),
        .state_in  (ma_out),
        .state_out (ss_out),
        .done      (ss_done)
    );

    mix_add_unit mix_add_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .go        (ma_go),
        .round     (key_round),
        .state_in  (ma_in),
        .state_out (ma_out),
        .done      (ma_done)
    );

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state      <= aes_ctrl_pkg::IDLE;
            round      <= '0;
            done_q     <= 1'b0;
            ciphertext <= '0;
        end
        else
        begin
            done_q <= 1'b0;
            case (state)
                aes_ctrl_pkg::IDLE:
                    if (start)
                        state <= aes_ctrl_pkg::KEY0;
                // Add result is back one cycle after go
                aes_ctrl_pkg::KEY0, aes_ctrl_pkg::MIXADD:
                    if (ma_done)
                    begin
                        if (last)
                        begin
                            state      <= aes_ctrl_pkg::IDLE;
                            round      <= '0;
                            done_q     <= 1'b1;
                            ciphertext <= ma_out;
                        end
                        else
                        begin
                            state <= aes_ctrl_pkg::SUBSHIFT;
                            round <= round + 1'b1;
                        end
                    end
                aes_ctrl_pkg::SUBSHIFT:
                    if (ss_done)
                        state <= aes_ctrl_pkg::MIXADD;
                default:
                    state <= aes_ctrl_pkg::IDLE;
            endcase
        end
    end

    always_comb
    begin
        status.busy  = (state != aes_ctrl_pkg::IDLE);
        status.done  = done_q;
        status.round = round;
    end

    // done is a single pulse per run
    assert property (@(posedge clk) disable iff (!rst_n) status.done |=> !status.done)
        else $error("done held for more than one cycle");

    // Round counter wraps back to 0 after round 14
    assert property (@(posedge clk) disable iff (!rst_n) round <= aes_pkg::NUM_ROUNDS)
        else $error("round counter past last round");

endmodule

/* hw/aes_ctrl_pkg.sv */
// Round controller state encoding and status word

package aes_ctrl_pkg;

    // Round sequencer states
    typedef enum logic [1:0] {
        IDLE,
        KEY0,
        SUBSHIFT,
        MIXADD
    } enc_state_e;

    // Status seen from outside the core
    // done is a single-cycle pulse, round follows the round counter
    typedef struct packed {
        logic            busy;
        logic            done;
        aes_pkg::round_t round;
    } enc_status_t;

endpackage

/* hw/aes_pkg.sv */
// Cipher data types and AES-256 constants
// Shared by the S-box, key ROM and round datapath

package aes_pkg;

    // One state byte or S-box entry
    typedef logic [7:0] byte_t;

    // Full 128-bit state or round key
    // Byte 0 sits in bits 127:120 and bytes run column by column
    typedef logic [127:0] block_t;

    // Round index
    // Round 0 is the initial AddRoundKey, rounds 1 to 14 are full rounds
    typedef logic [3:0] round_t;

    // Byte position within a block
    // Bits 1:0 give the row, bits 3:2 give the column
    typedef logic [3:0] byte_idx_t;

    // Last round index for a 256-bit key
    // This round skips MixColumns
    localparam round_t NUM_ROUNDS = 4'd14;

endpackage

/* hw/mix_add_unit.sv */
// MixColumns followed by AddRoundKey
// MixColumns is bypassed in rounds 0 and 14

module mix_add_unit (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            go,
    input  aes_pkg::round_t round,
    input  aes_pkg::block_t state_in,
    output aes_pkg::block_t state_out,
    output logic            done
);

    aes_pkg::block_t round_key;
    aes_pkg::block_t mixed;
    logic            bypass;

    // Multiply by x in GF(2^8)
    function automatic aes_pkg::byte_t xtime(aes_pkg::byte_t b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

    // One column times the fixed matrix 2 3 1 1
    function automatic logic [31:0] mix_column(logic [31:0] col);
        aes_pkg::byte_t a0;
        aes_pkg::byte_t a1;
        aes_pkg::byte_t a2;
        aes_pkg::byte_t a3;
        a0 = col[31:24];
        a1 = col[23:16];
        a2 = col[15:8];
        a3 = col[7:0];
        return {xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3,
                a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3,
                a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3,
                xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3)};
    endfunction

    // Key ROM follows the round index every cycle
    // Round is stable ahead of go, so the key is already valid
    round_key_rom key_rom_i (
        .clk   (clk),
        .round (round),
        .key   (round_key)
    );

    assign bypass = (round == '0) || (round == aes_pkg::NUM_ROUNDS);

    // Columns 0 to 3 from the top of the block down
    always_comb
    begin
        for (int c = 0; c < 4; c++)
            mixed[127 - 32*c -: 32] = mix_column(state_in[127 - 32*c -: 32]);
    end

    // Result is held until the next go
    always_ff @(posedge clk)
    begin
        if (go)
            state_out <= (bypass ? state_in : mixed) ^ round_key;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            done <= 1'b0;
        else
            done <= go;
    end

endmodule

/* hw/round_key_rom.sv */
// Round key store for the fixed AES-256 key 000102..1e1f
// Registered read of one 128-bit round key per cycle

module round_key_rom (
    input  logic            clk,
    input  aes_pkg::round_t round,
    output aes_pkg::block_t key
);

    // Expanded key schedule, round 0 first
    // Rounds 0 and 1 are the cipher key itself
    localparam aes_pkg::block_t [0:14] ROUND_KEYS = {
        128'h00010203_04050607_08090a0b_0c0d0e0f,
        128'h10111213_14151617_18191a1b_1c1d1e1f,
        128'ha573c29f_a176c498_a97fce93_a572c09c,
        128'h1651a8cd_0244beda_1a5da4c1_0640bade,
        128'hae87dff0_0ff11b68_a68ed5fb_03fc1567,
        128'h6de1f148_6fa54f92_75f8eb53_73b8518d,
        128'hc656827f_c9a79917_6f294cec_6cd5598b,
        128'h3de23a75_524775e7_27bf9eb4_5407cf39,
        128'h0bdc905f_c27b0948_ad5245a4_c1871c2f,
        128'h45f5a660_17b2d387_300d4d33_640a820a,
        128'h7ccff71c_beb4fe54_13e6bbf0_d261a7df,
        128'hf01afafe_e7a82979_d7a5644a_b3afe640,
        128'h2541fe71_9bf50025_8813bbd5_5a721c0a,
        128'h4e5a6699_a9f24fe0_7e572baa_cdf8cdea,
        128'h24fc79cc_bf0979e9_371ac23c_6d68de36
    };

    always_ff @(posedge clk)
    begin
        key <= ROUND_KEYS[round];
    end

    // The round index driven by the controller stays inside the schedule
    assert property (@(posedge clk) round <= aes_pkg::NUM_ROUNDS)
        else $error("round key index %0d out of range", round);

endmodule

/* hw/sbox_rom.sv */
// Forward AES S-box with a registered read port

module sbox_rom (
    input  logic           clk,
    input  aes_pkg::byte_t addr,
    output aes_pkg::byte_t data
);

    // Forward S-box, one row of 16 entries per line
    // Entry 0 is the leftmost byte of the first line
    localparam aes_pkg::byte_t [0:255] SBOX = {
        128'h637c777b_f26b6fc5_3001672b_fed7ab76,
        128'hca82c97d_fa5947f0_add4a2af_9ca472c0,
        128'hb7fd9326_363ff7cc_34a5e5f1_71d83115,
        128'h04c723c3_1896059a_071280e2_eb27b275,
        128'h09832c1a_1b6e5aa0_523bd6b3_29e32f84,
        128'h53d100ed_20fcb15b_6acbbe39_4a4c58cf,
        128'hd0efaafb_434d3385_45f9027f_503c9fa8,
        128'h51a3408f_929d38f5_bcb6da21_10fff3d2,
        128'hcd0c13ec_5f974417_c4a77e3d_645d1973,
        128'h60814fdc_222a9088_46eeb814_de5e0bdb,
        128'he0323a0a_4906245c_c2d3ac62_9195e479,
        128'he7c8376d_8dd54ea9_6c56f4ea_657aae08,
        128'hba78252e_1ca6b4c6_e8dd741f_4bbd8b8a,
        128'h703eb566_4803f60e_613557b9_86c11d9e,
        128'he1f89811_69d98e94_9b1e87e9_ce5528df,
        128'h8ca1890d_bfe64268_41992d0f_b054bb16
    };

    // One lookup per cycle, data valid after the sampling edge
    always_ff @(posedge clk)
    begin
        data <= SBOX[addr];
    end

endmodule

/* hw/sub_shift_unit.sv */
// Byte-serial SubBytes through the S-box ROM
// Each substituted byte is stored at its ShiftRows position

module sub_shift_unit (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            go,
    input  aes_pkg::block_t state_in,
    output aes_pkg::block_t state_out,
    output logic            done
);

    // Read side walking over the input block
    logic               walking;
    aes_pkg::byte_idx_t idx;
    aes_pkg::byte_idx_t rd_idx;
    aes_pkg::byte_t     sbox_addr;
    aes_pkg::byte_t     sbox_data;

    // Write side, one cycle behind the read side
    logic               wr_vld;
    aes_pkg::byte_idx_t wr_idx;

    // ShiftRows destination of a source byte
    // Row r rotates left by r columns
    function automatic aes_pkg::byte_idx_t shift_dest(aes_pkg::byte_idx_t src);
        logic [1:0] row;
        logic [1:0] col;
        row = src[1:0];
        col = src[3:2] - row;
        return {col, row};
    endfunction

    // Byte 0 goes out in the go cycle, the rest follow from the counter
    assign rd_idx    = walking ? idx : '0;
    assign sbox_addr = state_in[8*(15 - rd_idx) +: 8];

    sbox_rom sbox_i (
        .clk  (clk),
        .addr (sbox_addr),
        .data (sbox_data)
    );

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            walking <= 1'b0;
            idx     <= '0;
            wr_vld  <= 1'b0;
            wr_idx  <= '0;
            done    <= 1'b0;
        end
        else
        begin
            // Track which byte the S-box is returning
            wr_vld <= go || walking;
            wr_idx <= rd_idx;
            // Last byte lands together with done
            done   <= wr_vld && (wr_idx == 4'd15);
            if (go)
            begin
                walking <= 1'b1;
                idx     <= 4'd1;
            end
            else if (walking)
            begin
                idx <= idx + 1'b1;
                if (idx == 4'd15)
                    walking <= 1'b0;
            end
        end
    end

    // Output block is rebuilt byte by byte and then held
    always_ff @(posedge clk)
    begin
        if (wr_vld)
            state_out[8*(15 - shift_dest(wr_idx)) +: 8] <= sbox_data;
    end

    // Controller must not restart the unit mid-block
    assert property (@(posedge clk) disable iff (!rst_n) go |-> !walking)
        else $error("sub_shift_unit restarted while walking");

endmodule

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_aes256_enc -f build.f
sim_out=$(./obj_dir/Vtb_aes256_enc 2>&1) || true
echo "$sim_out"
if echo "$sim_out" | grep -q "Simulation passed"; then
    exit 0
fi
exit 1

/* tb/aes256_golden.txt */
# AES-256 with key 000102030405060708090a0b0c0d0e0f101112131415161718191a1b1c1d1e1f
# Columns: plaintext ciphertext, each 128 bits in hex, byte 0 first
00112233445566778899aabbccddeeff 8ea2b7ca516745bfeafc49904b496089
00112233445566778899aabbccddeeff 8ea2b7ca516745bfeafc49904b496089
00112233445566778899aabbccddeeff 8ea2b7ca516745bfeafc49904b496089

/* tb/tb_aes256_enc.sv */
// Testbench for the AES-256 encryption core
// Golden vectors, ignored starts, done latency and reset in mid-run

module tb_aes256_enc;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int DONE_LATENCY   = 253;
    localparam int TIMEOUT_CYCLES = 400;
    localparam aes_ctrl_pkg::enc_status_t IDLE_STATUS = '{busy: 1'b0, done: 1'b0, round: 4'd0};
    // Initial AddRoundKey right after an accepted start
    localparam aes_ctrl_pkg::enc_status_t KEY0_STATUS = '{busy: 1'b1, done: 1'b0, round: 4'd0};

    logic                      clk;
    logic                      rst_n;
    logic                      start;
    aes_pkg::block_t           plaintext;
    aes_pkg::block_t           ciphertext;
    aes_ctrl_pkg::enc_status_t status;

    // Golden pairs from the vector file
    aes_pkg::block_t golden_pt[$];
    aes_pkg::block_t golden_ct[$];

    aes256_enc dut_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .plaintext  (plaintext),
        .ciphertext (ciphertext),
        .status     (status)
    );

    // 40 ns period
    always
    begin
        #20 clk = ~clk;
    end

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_block(input string name, input aes_pkg::block_t expected,
                               input aes_pkg::block_t actual);
        if (actual !== expected)
            report_failure($sformatf("[ERROR] %s expected %h actual %h", name, expected, actual));
    endtask

    task automatic check_status(input aes_ctrl_pkg::enc_status_t expected,
                                input aes_ctrl_pkg::enc_status_t actual);
        if (actual !== expected)
            report_failure($sformatf("[ERROR] status expected %h actual %h", expected, actual));
    endtask

    task automatic check_latency(input int expected, input int actual);
        if (actual != expected)
            report_failure($sformatf("[ERROR] done latency expected %h actual %h",
                                     expected, actual));
    endtask

    // Lines starting with # are column notes
    task automatic load_vectors();
        int              fd;
        int              fields;
        string           line;
        aes_pkg::block_t pt;
        aes_pkg::block_t ct;
        fd = $fopen("tb/aes256_golden.txt", "r");
        if (fd == 0)
            report_failure("Could not open the golden vector file tb/aes256_golden.txt");
        while (!$feof(fd))
        begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line.getc(0) != "#")
            begin
                fields = $sscanf(line, "%h %h", pt, ct);
                if (fields == 2)
                begin
                    golden_pt.push_back(pt);
                    golden_ct.push_back(ct);
                end
            end
        end
        $fclose(fd);
        if (golden_pt.size() == 0)
            report_failure("The golden vector file holds no vectors");
    endtask

    // Called 2 ns past an edge, returns 2 ns past the edge that accepted start
    task automatic start_run(input aes_pkg::block_t pt);
        start     = 1'b1;
        plaintext = pt;
        @(posedge clk);
        #2;
        start = 1'b0;
        // Busy in round 0 and any earlier done pulse is gone
        check_status(KEY0_STATUS, status);
    endtask

    // Counts edges up to the done cycle, optionally with garbage starts while busy
    task automatic wait_done(input bit inject, output int cycles);
        bit done_seen;
        cycles    = 0;
        done_seen = 1'b0;
        while (!done_seen && cycles < TIMEOUT_CYCLES)
        begin
            @(posedge clk);
            cycles++;
            #2;
            if (status.done)
                done_seen = 1'b1;
            else
            begin
                if (!status.busy)
                    report_failure("The core dropped busy before done");
                if (inject)
                begin
                    start     = 1'($urandom_range(0, 1));
                    plaintext = {$urandom, $urandom, $urandom, $urandom};
                end
            end
        end
        if (!done_seen)
            report_failure("Timed out after 400 cycles waiting for done");
        start = 1'b0;
    endtask

    // A gap of 0 lets the next run start in the done cycle itself
    task automatic run_vector(input aes_pkg::block_t pt, input aes_pkg::block_t ct,
                              input bit inject);
        int cycles;
        int gap;
        start_run(pt);
        wait_done(inject, cycles);
        check_latency(DONE_LATENCY, cycles);
        check_block("ciphertext", ct, ciphertext);
        // done is gone and ciphertext holds while idle
        gap = $urandom_range(0, 5);
        repeat (gap)
        begin
            @(posedge clk);
            #2;
            check_status(IDLE_STATUS, status);
            check_block("ciphertext", ct, ciphertext);
        end
    endtask

    task automatic reset_mid_run(input aes_pkg::block_t pt);
        start_run(pt);
        repeat (120) @(posedge clk);
        #2;
        if (!status.busy)
            report_failure("The core was not busy when reset was applied");
        rst_n = 1'b0;
        // Asynchronous clear
        #1;
        check_status(IDLE_STATUS, status);
        check_block("ciphertext", '0, ciphertext);
        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;
    endtask

    initial
    begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        start     = 1'b0;
        plaintext = '0;
        void'($urandom(32'h63da_895b));
        load_vectors();
        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;
        // Idle after reset
        repeat (3)
        begin
            @(posedge clk);
            #2;
            check_status(IDLE_STATUS, status);
            check_block("ciphertext", '0, ciphertext);
        end
        // Clean runs, then runs with stray starts while busy
        foreach (golden_pt[i])
            run_vector(golden_pt[i], golden_ct[i], 1'b0);
        foreach (golden_pt[i])
            run_vector(golden_pt[i], golden_ct[i], 1'b1);
        // Reset in the middle of a run, then recover
        reset_mid_run({$urandom, $urandom, $urandom, $urandom});
        run_vector(golden_pt[0], golden_ct[0], 1'b0);
        // Last done pulse drops as well
        @(posedge clk);
        #2;
        check_status(IDLE_STATUS, status);
        check_block("ciphertext", golden_ct[0], ciphertext);
        $display("Simulation passed");
        $finish;
    end

endmodule
